//--- common/vdp_pkg.sv
// shared types and constants for the video display processor
// word, address, palette index and colour types
// register numbers of the host register file
// default raster timing and video memory depth

package vdp_pkg;

    typedef logic [15:0] word_t;    // four pixel indices, first pixel in high nibble
    typedef logic [15:0] vaddr_t;   // video memory word address
    typedef logic [3:0]  pal_idx_t; // palette entry number
    typedef logic [2:0]  reg_num_t;

    // 12-bit colour, 4 bits per gun
    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

    // host register map
    localparam reg_num_t REG_WR_ADDR  = 3'd0;   // vram write address
    localparam reg_num_t REG_DATA     = 3'd1;   // write word, then add increment
    localparam reg_num_t REG_WR_INCR  = 3'd2;
    localparam reg_num_t REG_RD_ADDR  = 3'd3;   // write starts a prefetch
    localparam reg_num_t REG_RD_DATA  = 3'd4;   // odd byte read advances
    localparam reg_num_t REG_PAL_ADDR = 3'd5;
    localparam reg_num_t REG_PAL_DATA = 3'd6;   // write colour, bump palette address
    localparam reg_num_t REG_CTRL     = 3'd7;

    // bits of REG_CTRL
    localparam int CTRL_VIDEO_EN_BIT = 0;
    localparam int CTRL_BUSY_BIT     = 15;      // read only

    localparam int PIX_PER_WORD = 4;            // nibbles per vram word

    // tiny default raster
    localparam int DEF_H_VISIBLE    = 16;
    localparam int DEF_H_TOTAL      = 24;
    localparam int DEF_H_SYNC_START = 18;
    localparam int DEF_H_SYNC_LEN   = 2;
    localparam int DEF_V_VISIBLE    = 4;
    localparam int DEF_V_TOTAL      = 6;
    localparam int DEF_V_SYNC_START = 4;
    localparam int DEF_V_SYNC_LEN   = 1;
    localparam int DEF_VRAM_WORDS   = 1024;

endpackage

//--- common/ram_if.sv
// memory port bundle
// one write port and one registered read port, payload set by type

interface ram_if #(
    parameter type data_t = logic [15:0],
    parameter int  ADDR_W = 10
) ();
    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    data_t             wr_data;
    logic              rd_en;
    logic [ADDR_W-1:0] rd_addr;
    data_t             rd_data;     // valid the cycle after rd_en

    modport mem  (input wr_en, wr_addr, wr_data, rd_en, rd_addr, output rd_data);
    modport user (output wr_en, wr_addr, wr_data, rd_en, rd_addr, input rd_data);
endinterface

//--- hw/vdp_ram.sv
// simple dual port synchronous memory
// one write and one registered read per cycle
// same-address read and write returns the old contents

module vdp_ram #(
    parameter type data_t = logic [15:0],
    parameter int  DEPTH  = 1024
) (
    input logic clk,
    ram_if.mem  mem
);
    data_t ram [DEPTH];     // no reset on storage

    always_ff @(posedge clk) begin
        if (mem.wr_en) begin
            ram[mem.wr_addr] <= mem.wr_data;
        end
        // nonblocking, so a colliding read sees old data
        if (mem.rd_en) begin
            mem.rd_data <= ram[mem.rd_addr];
        end
    end

endmodule

//--- hw/bus_port.sv
// host bus port
// two-flop synchroniser, chip select edge detect
// byte assembly into register write words
// read-back byte select, prefetch read acknowledge

module bus_port (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              bus_cs_n_i,       // strobe, active low
    input  logic              bus_rd_nwr_i,     // 1 = read
    input  vdp_pkg::reg_num_t bus_reg_num_i,
    input  logic              bus_bytesel_i,    // 1 = odd (low) byte
    input  logic [7:0]        bus_data_i,
    output logic [7:0]        bus_data_o,
    input  vdp_pkg::word_t    reg_rdata_i,      // word of the addressed register
    output logic              reg_wr_o,
    output vdp_pkg::reg_num_t reg_num_o,
    output vdp_pkg::word_t    reg_data_o,
    output logic              rd_ack_o
);
    import vdp_pkg::*;

    logic       cs_n_s1, cs_n_s2, cs_n_q;
    logic       rd_nwr_s1, rd_nwr_s2;
    reg_num_t   num_s1, num_s2;
    logic       bytesel_s1, bytesel_s2;
    logic [7:0] data_s1, data_s2;
    logic [7:0] hi_byte;                    // pending even byte
    logic       strobe;

    // chip select sync, idles high
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cs_n_s1 <= 1'b1;
            cs_n_s2 <= 1'b1;
            cs_n_q  <= 1'b1;
        end else begin
            cs_n_s1 <= bus_cs_n_i;
            cs_n_s2 <= cs_n_s1;
            cs_n_q  <= cs_n_s2;             // for edge detect
        end
    end

    // qualifiers only looked at around the strobe
    always_ff @(posedge clk) begin
        rd_nwr_s1  <= bus_rd_nwr_i;
        rd_nwr_s2  <= rd_nwr_s1;
        num_s1     <= bus_reg_num_i;
        num_s2     <= num_s1;
        bytesel_s1 <= bus_bytesel_i;
        bytesel_s2 <= bytesel_s1;
        data_s1    <= bus_data_i;
        data_s2    <= data_s1;
        if (strobe && !rd_nwr_s2 && !bytesel_s2) begin
            hi_byte <= data_s2;             // even byte waits for odd
        end
    end

    assign strobe = cs_n_q & ~cs_n_s2;      // falling edge of sync'd cs

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            reg_wr_o   <= 1'b0;
            rd_ack_o   <= 1'b0;
            bus_data_o <= 8'h00;
        end else begin
            reg_wr_o <= strobe & ~rd_nwr_s2 & bytesel_s2;  // odd byte completes word
            rd_ack_o <= strobe & rd_nwr_s2 & bytesel_s2 & (num_s2 == REG_RD_DATA);
            if (cs_n_s2) begin
                bus_data_o <= 8'h00;
            end else if (strobe && rd_nwr_s2) begin
                // latched once, so a following prefetch cannot change it
                bus_data_o <= bytesel_s2 ? reg_rdata_i[7:0] : reg_rdata_i[15:8];
            end
        end
    end

    assign reg_num_o  = num_s2;
    assign reg_data_o = {hi_byte, data_s2};

endmodule

//--- blit/blitter.sv
// register file and host memory access engine
// vram write queue with address increment
// vram read prefetch with auto advance
// palette writes, control and status read-back

module blitter #(
    parameter int VRAM_AW = 10
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              reg_wr_i,
    input  vdp_pkg::reg_num_t reg_num_i,
    input  vdp_pkg::word_t    reg_data_i,
    input  logic              rd_ack_i,
    input  logic              blit_slot_i,      // vram free for us this cycle
    ram_if.user               vram,             // write side and rd_data
    output logic              vram_rd_en_o,
    output vdp_pkg::vaddr_t   vram_rd_addr_o,
    ram_if.user               pal,              // write side only
    output vdp_pkg::word_t    reg_rdata_o,
    output logic              video_en_o
);
    import vdp_pkg::*;

    vaddr_t   wr_addr, wr_incr, rd_addr;
    word_t    wr_word;                  // queued write payload
    word_t    rd_word;                  // prefetched word
    pal_idx_t pal_addr;
    logic     wr_pend;
    logic     pf_pend;                  // prefetch waiting for a slot
    logic     pf_wait;                  // prefetch issued, data next cycle
    logic     busy;
    logic     wr_go, pf_go;

    assign wr_go = wr_pend & blit_slot_i;
    assign pf_go = pf_pend & blit_slot_i;
    assign busy  = wr_pend | pf_pend | pf_wait;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_addr    <= '0;
            wr_incr    <= '0;
            rd_addr    <= '0;
            pal_addr   <= '0;
            video_en_o <= 1'b0;
            wr_pend    <= 1'b0;
            pf_pend    <= 1'b0;
            pf_wait    <= 1'b0;
        end else begin
            // service side, at most one of each per slot
            if (wr_go) begin
                wr_pend <= 1'b0;
                wr_addr <= wr_addr + wr_incr;
            end
            if (pf_go) begin
                pf_pend <= 1'b0;
            end
            pf_wait <= pf_go;

            if (rd_ack_i) begin
                rd_addr <= rd_addr + 1'b1;  // odd byte read, fetch next word
                pf_pend <= 1'b1;
            end

            if (reg_wr_i) begin
                case (reg_num_i)
                    REG_WR_ADDR:  wr_addr <= reg_data_i;
                    REG_DATA:     wr_pend <= 1'b1;
                    REG_WR_INCR:  wr_incr <= reg_data_i;
                    REG_RD_ADDR: begin
                        rd_addr <= reg_data_i;
                        pf_pend <= 1'b1;
                    end
                    REG_PAL_ADDR: pal_addr <= reg_data_i[3:0];
                    REG_PAL_DATA: pal_addr <= pal_addr + 1'b1;  // entry written below
                    REG_CTRL:     video_en_o <= reg_data_i[CTRL_VIDEO_EN_BIT];
                    default: ;
                endcase
            end
        end
    end

    // payload regs
    always_ff @(posedge clk) begin
        if (reg_wr_i && reg_num_i == REG_DATA) begin
            wr_word <= reg_data_i;
        end
        if (pf_wait) begin
            rd_word <= vram.rd_data;        // one cycle behind the read
        end
    end

    // vram write port, only in slot cycles
    assign vram.wr_en   = wr_go;
    assign vram.wr_addr = wr_addr[VRAM_AW-1:0];
    assign vram.wr_data = wr_word;

    // read request, top level muxes it onto the port
    assign vram_rd_en_o   = pf_go;
    assign vram_rd_addr_o = rd_addr;

    // palette port is ours alone, write straight through
    assign pal.wr_en   = reg_wr_i && (reg_num_i == REG_PAL_DATA);
    assign pal.wr_addr = pal_addr;
    assign pal.wr_data = rgb_t'(reg_data_i[11:0]);

    // read-back mux
    always_comb begin
        reg_rdata_o = '0;                   // write-only regs read 0
        case (reg_num_i)
            REG_WR_ADDR:  reg_rdata_o = wr_addr;
            REG_WR_INCR:  reg_rdata_o = wr_incr;
            REG_RD_ADDR:  reg_rdata_o = rd_addr;
            REG_RD_DATA:  reg_rdata_o = rd_word;
            REG_PAL_ADDR: reg_rdata_o = word_t'(pal_addr);
            REG_CTRL: begin
                reg_rdata_o[CTRL_VIDEO_EN_BIT] = video_en_o;
                reg_rdata_o[CTRL_BUSY_BIT]     = busy;
            end
            default: ;
        endcase
    end

endmodule

//--- video/video_gen.sv
// raster generator
// column and line counters, vram fetch scheduling
// nibble shifter, palette lookup, sync and visible pipeline

module video_gen #(
    parameter int H_VISIBLE    = 16,
    parameter int H_TOTAL      = 24,
    parameter int H_SYNC_START = 18,
    parameter int H_SYNC_LEN   = 2,
    parameter int V_VISIBLE    = 4,
    parameter int V_TOTAL      = 6,
    parameter int V_SYNC_START = 4,
    parameter int V_SYNC_LEN   = 1
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            video_en_i,
    output logic            blit_slot_o,    // vram read port free for host
    output logic            vram_rd_en_o,
    output vdp_pkg::vaddr_t vram_rd_addr_o,
    input  vdp_pkg::word_t  vram_rd_data_i,
    ram_if.user             pal,            // read side only
    output logic [3:0]      red_o,
    output logic [3:0]      green_o,
    output logic [3:0]      blue_o,
    output logic            hsync_o,        // active low
    output logic            vsync_o,        // active low
    output logic            visible_o
);
    import vdp_pkg::*;

    localparam int HW = $clog2(H_TOTAL);
    localparam int VW = $clog2(V_TOTAL);
    localparam int PW = $clog2(PIX_PER_WORD);

    logic [HW-1:0] h_cnt, h_nxt;
    logic [VW-1:0] v_cnt, v_nxt;
    vaddr_t        addr_cnt;            // next word to fetch
    word_t         shreg;               // remaining nibbles of current group
    pal_idx_t      idx;
    logic          fetch, vis;
    logic          vis_q, hs_q, vs_q, en_q;
    rgb_t          pixel;

    // position of the next cycle, fetch looks one ahead
    always_comb begin
        h_nxt = h_cnt + 1'b1;
        v_nxt = v_cnt;
        if (h_cnt == HW'(H_TOTAL - 1)) begin
            h_nxt = '0;
            v_nxt = (v_cnt == VW'(V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;
        end
    end

    // fetch in the last column before each group
    assign fetch = (h_nxt[PW-1:0] == '0) && (h_nxt < HW'(H_VISIBLE))
                   && (v_nxt < VW'(V_VISIBLE));
    assign vis   = (h_cnt < HW'(H_VISIBLE)) && (v_cnt < VW'(V_VISIBLE));

    assign blit_slot_o    = ~fetch;
    assign vram_rd_en_o   = fetch;
    assign vram_rd_addr_o = addr_cnt;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            h_cnt    <= HW'(H_TOTAL - 1);   // first frame starts clean
            v_cnt    <= VW'(V_TOTAL - 1);
            addr_cnt <= '0;
        end else begin
            h_cnt <= h_nxt;
            v_cnt <= v_nxt;
            if (fetch) begin
                addr_cnt <= addr_cnt + 1'b1;    // lines are back to back
            end else if (v_cnt == VW'(V_VISIBLE)) begin
                addr_cnt <= '0;                 // rewind in vertical blank
            end
        end
    end

    // first nibble straight from memory, rest from the shifter
    assign idx = (h_cnt[PW-1:0] == '0) ? vram_rd_data_i[15:12] : shreg[15:12];

    always_ff @(posedge clk) begin
        if (h_cnt[PW-1:0] == '0) begin
            shreg <= vram_rd_data_i << 4;
        end else begin
            shreg <= shreg << 4;
        end
    end

    assign pal.rd_en   = vis;
    assign pal.rd_addr = idx;

    // one stage to match the palette read
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            vis_q <= 1'b0;
            hs_q  <= 1'b1;
            vs_q  <= 1'b1;
            en_q  <= 1'b0;
        end else begin
            vis_q <= vis;
            hs_q  <= !((h_cnt >= HW'(H_SYNC_START))
                       && (h_cnt < HW'(H_SYNC_START + H_SYNC_LEN)));
            vs_q  <= !((v_cnt >= VW'(V_SYNC_START))
                       && (v_cnt < VW'(V_SYNC_START + V_SYNC_LEN)));
            en_q  <= video_en_i;
        end
    end

    assign pixel     = (en_q && vis_q) ? pal.rd_data : '0;   // black when off
    assign red_o     = pixel.red;
    assign green_o   = pixel.green;
    assign blue_o    = pixel.blue;
    assign hsync_o   = hs_q;
    assign vsync_o   = vs_q;
    assign visible_o = vis_q;

endmodule

//--- hw/vdp_top.sv
// video display processor top level
// bus port, blitter, video generator
// video memory and palette with their port bundles
// vram read port arbitration by access slot

module vdp_top #(
    parameter int H_VISIBLE    = vdp_pkg::DEF_H_VISIBLE,
    parameter int H_TOTAL      = vdp_pkg::DEF_H_TOTAL,
    parameter int H_SYNC_START = vdp_pkg::DEF_H_SYNC_START,
    parameter int H_SYNC_LEN   = vdp_pkg::DEF_H_SYNC_LEN,
    parameter int V_VISIBLE    = vdp_pkg::DEF_V_VISIBLE,
    parameter int V_TOTAL      = vdp_pkg::DEF_V_TOTAL,
    parameter int V_SYNC_START = vdp_pkg::DEF_V_SYNC_START,
    parameter int V_SYNC_LEN   = vdp_pkg::DEF_V_SYNC_LEN,
    parameter int VRAM_WORDS   = vdp_pkg::DEF_VRAM_WORDS
) (
    input  logic              clk,              // pixel clock
    input  logic              rst_n_i,
    input  logic              bus_cs_n_i,
    input  logic              bus_rd_nwr_i,
    input  vdp_pkg::reg_num_t bus_reg_num_i,
    input  logic              bus_bytesel_i,
    input  logic [7:0]        bus_data_i,
    output logic [7:0]        bus_data_o,
    output logic [3:0]        red_o,
    output logic [3:0]        green_o,
    output logic [3:0]        blue_o,
    output logic              hsync_o,
    output logic              vsync_o,
    output logic              visible_o
);
    import vdp_pkg::*;

    localparam int VRAM_AW = $clog2(VRAM_WORDS);

    logic     reg_wr, rd_ack, video_en, blit_slot;
    reg_num_t reg_num;
    word_t    reg_data, reg_rdata;
    logic     blit_rd_en, vg_rd_en;
    vaddr_t   blit_rd_addr, vg_rd_addr;

    ram_if #(.data_t(word_t), .ADDR_W(VRAM_AW))          vram_bus ();
    ram_if #(.data_t(rgb_t),  .ADDR_W($bits(pal_idx_t))) pal_bus ();

    bus_port u_bus_port (
        .clk, .rst_n_i, .bus_cs_n_i, .bus_rd_nwr_i, .bus_reg_num_i,
        .bus_bytesel_i, .bus_data_i, .bus_data_o,
        .reg_rdata_i (reg_rdata),
        .reg_wr_o    (reg_wr),
        .reg_num_o   (reg_num),
        .reg_data_o  (reg_data),
        .rd_ack_o    (rd_ack)
    );

    blitter #(.VRAM_AW(VRAM_AW)) u_blitter (
        .clk, .rst_n_i,
        .reg_wr_i       (reg_wr),
        .reg_num_i      (reg_num),
        .reg_data_i     (reg_data),
        .rd_ack_i       (rd_ack),
        .blit_slot_i    (blit_slot),
        .vram           (vram_bus),
        .vram_rd_en_o   (blit_rd_en),
        .vram_rd_addr_o (blit_rd_addr),
        .pal            (pal_bus),
        .reg_rdata_o    (reg_rdata),
        .video_en_o     (video_en)
    );

    video_gen #(
        .H_VISIBLE(H_VISIBLE), .H_TOTAL(H_TOTAL),
        .H_SYNC_START(H_SYNC_START), .H_SYNC_LEN(H_SYNC_LEN),
        .V_VISIBLE(V_VISIBLE), .V_TOTAL(V_TOTAL),
        .V_SYNC_START(V_SYNC_START), .V_SYNC_LEN(V_SYNC_LEN)
    ) u_video_gen (
        .clk, .rst_n_i,
        .video_en_i     (video_en),
        .blit_slot_o    (blit_slot),
        .vram_rd_en_o   (vg_rd_en),
        .vram_rd_addr_o (vg_rd_addr),
        .vram_rd_data_i (vram_bus.rd_data),
        .pal            (pal_bus),
        .red_o, .green_o, .blue_o, .hsync_o, .vsync_o, .visible_o
    );

    // read port goes to the host engine in slot cycles, else to video
    assign vram_bus.rd_en   = blit_slot ? blit_rd_en : vg_rd_en;
    assign vram_bus.rd_addr = blit_slot ? blit_rd_addr[VRAM_AW-1:0]
                                        : vg_rd_addr[VRAM_AW-1:0];

    vdp_ram #(.data_t(word_t), .DEPTH(VRAM_WORDS)) u_vram (
        .clk,
        .mem (vram_bus)
    );

    vdp_ram #(.data_t(rgb_t), .DEPTH(2 ** $bits(pal_idx_t))) u_palette (
        .clk,
        .mem (pal_bus)
    );

endmodule

//--- tb/vdp_clkgen.sv
// testbench clock and reset source
// free running clock, reset held low for a few rising edges

module vdp_clkgen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // released on a rising edge, flops still see reset at that edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

//--- tb/vdp_checker.sv
// bound protocol assertions for the display processor
// one-cycle register strobes, vram write served soon after a data write
// horizontal sync never active in the visible area

module vdp_checker (
    input logic              clk_i,
    input logic              rst_n_i,
    input logic              reg_wr_i,
    input vdp_pkg::reg_num_t reg_num_i,
    input logic              rd_ack_i,
    input logic              vram_wr_en_i,
    input logic              hsync_i,        // active low
    input logic              visible_i
);
    timeunit 1ns;
    timeprecision 100ps;

    a_reg_wr_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        reg_wr_i |=> !reg_wr_i)
        else $error("register write strobe longer than one cycle");

    a_rd_ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rd_ack_i |=> !rd_ack_i)
        else $error("read acknowledge longer than one cycle");

    // queued word reaches vram in the first free slot
    a_wr_served: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (reg_wr_i && reg_num_i == vdp_pkg::REG_DATA) |-> ##[1:2] vram_wr_en_i)
        else $error("video memory write not issued within two cycles");

    a_no_hsync_visible: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        visible_i |-> hsync_i)
        else $error("hsync active during visible pixels");

endmodule

bind vdp_top vdp_checker u_checker (
    .clk_i        (clk),
    .rst_n_i      (rst_n_i),
    .reg_wr_i     (reg_wr),
    .reg_num_i    (reg_num),
    .rd_ack_i     (rd_ack),
    .vram_wr_en_i (vram_bus.wr_en),
    .hsync_i      (hsync_o),
    .visible_i    (visible_o)
);

//--- tb/vdp_tb.sv
// testbench top for the video display processor
// host bus driver, register model of vram, palette and control
// read-back checks, full frame pixel and sync checks
// watchdog sized from the tests file

module vdp_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import vdp_pkg::*;

    localparam int H_VISIBLE     = DEF_H_VISIBLE;
    localparam int H_TOTAL       = DEF_H_TOTAL;
    localparam int V_VISIBLE     = DEF_V_VISIBLE;
    localparam int V_TOTAL       = DEF_V_TOTAL;
    localparam int V_SYNC_START  = DEF_V_SYNC_START;
    localparam int V_SYNC_LEN    = DEF_V_SYNC_LEN;
    localparam int VRAM_WORDS    = DEF_VRAM_WORDS;
    localparam int FRAME_CYC     = H_TOTAL * V_TOTAL;
    localparam int FRAME_PIX     = H_VISIBLE * V_VISIBLE;
    localparam int MID_FRAME_CYC = (V_TOTAL - V_SYNC_START + 1) * H_TOTAL;  // past line 0
    localparam int HOLD_CYC      = 4;
    localparam int GAP_CYC       = 8;
    localparam int STROBE_CYC    = HOLD_CYC + GAP_CYC + 4;  // incl. edge alignment
    localparam int SEED          = 5222;
    localparam string TESTS_FILE = "tb/vdp_tests.txt";

    logic       clk;
    logic       rst_n;
    logic       bus_cs_n = 1'b1;
    logic       bus_rd_nwr = 1'b0;
    reg_num_t   bus_reg_num = '0;
    logic       bus_bytesel = 1'b0;
    logic [7:0] bus_data = 8'h00;
    logic [7:0] bus_data_o;
    logic [3:0] red_o;
    logic [3:0] green_o;
    logic [3:0] blue_o;
    logic       hsync_o;
    logic       vsync_o;
    logic       visible_o;
    rgb_t       pix_out;

    // model of what the host wrote
    word_t    m_vram [VRAM_WORDS];
    rgb_t     m_pal [16];
    vaddr_t   m_wr_addr = '0;
    vaddr_t   m_incr = '0;
    pal_idx_t m_pal_addr = '0;
    logic     m_video_en = 1'b0;
    int       errors = 0;
    int       budget_cyc = 0;

    assign pix_out = {red_o, green_o, blue_o};

    vdp_clkgen #(.PERIOD_NS(40), .RESET_CYCLES(2)) u_clkgen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    vdp_top #(
        .H_VISIBLE(H_VISIBLE), .H_TOTAL(H_TOTAL),
        .H_SYNC_START(DEF_H_SYNC_START), .H_SYNC_LEN(DEF_H_SYNC_LEN),
        .V_VISIBLE(V_VISIBLE), .V_TOTAL(V_TOTAL),
        .V_SYNC_START(V_SYNC_START), .V_SYNC_LEN(V_SYNC_LEN),
        .VRAM_WORDS(VRAM_WORDS)
    ) dut (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .bus_cs_n_i    (bus_cs_n),
        .bus_rd_nwr_i  (bus_rd_nwr),
        .bus_reg_num_i (bus_reg_num),
        .bus_bytesel_i (bus_bytesel),
        .bus_data_i    (bus_data),
        .bus_data_o    (bus_data_o),
        .red_o, .green_o, .blue_o, .hsync_o, .vsync_o, .visible_o
    );

    task automatic stop_run(input string msg);
        errors++;
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            stop_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_rgb(input string name, input rgb_t got, input rgb_t exp);
        if (got !== exp) begin
            stop_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            stop_run($sformatf("mismatch %s: got %0h expected %0h", name, got, exp));
        end
    endtask

    // one byte strobe, cs held then released for the gap
    task automatic bus_cycle(input reg_num_t num, input logic odd, input logic rd,
                             input logic [7:0] wdata, output logic [7:0] rdata);
        @(posedge clk);
        bus_reg_num <= num;
        bus_bytesel <= odd;
        bus_rd_nwr  <= rd;
        bus_data    <= wdata;
        bus_cs_n    <= 1'b0;
        repeat (HOLD_CYC) @(posedge clk);
        @(negedge clk);
        rdata = bus_data_o;                 // settled well before release
        @(posedge clk);
        bus_cs_n <= 1'b1;
        repeat (GAP_CYC) @(posedge clk);
    endtask

    // register rules applied to the model
    task automatic model_write(input reg_num_t num, input word_t data);
        case (num)
            REG_WR_ADDR: m_wr_addr = data;
            REG_DATA: begin
                m_vram[m_wr_addr % VRAM_WORDS] = data;
                m_wr_addr = m_wr_addr + m_incr;
            end
            REG_WR_INCR:  m_incr = data;
            REG_PAL_ADDR: m_pal_addr = data[3:0];
            REG_PAL_DATA: begin
                m_pal[m_pal_addr] = data[11:0];
                m_pal_addr = m_pal_addr + 1'b1;
            end
            REG_CTRL: m_video_en = data[0];
            default: ;
        endcase
    endtask

    task automatic reg_write(input reg_num_t num, input word_t data);
        logic [7:0] dummy_byte;
        bus_cycle(num, 1'b0, 1'b0, data[15:8], dummy_byte);  // high byte first
        bus_cycle(num, 1'b1, 1'b0, data[7:0], dummy_byte);
        model_write(num, data);
    endtask

    task automatic reg_read(input reg_num_t num, output word_t data);
        logic [7:0] hi;
        logic [7:0] lo;
        bus_cycle(num, 1'b0, 1'b1, 8'h00, hi);
        bus_cycle(num, 1'b1, 1'b1, 8'h00, lo);  // odd byte may advance
        data = {hi, lo};
    endtask

    // k counts visible pixels from the top left of the frame
    function automatic rgb_t expected_pixel(input int k);
        int       x;
        int       y;
        word_t    w;
        pal_idx_t n;
        x = k % H_VISIBLE;
        y = k / H_VISIBLE;
        w = m_vram[y * (H_VISIBLE / PIX_PER_WORD) + x / PIX_PER_WORD];
        n = w[15 - 4 * (x % PIX_PER_WORD) -: 4];   // first pixel in high nibble
        expected_pixel = m_video_en ? m_pal[n] : rgb_t'('0);
    endfunction

    task automatic wait_vsync_fall();
        logic prev;
        @(negedge clk);
        prev = vsync_o;
        @(negedge clk);
        while (!(prev && !vsync_o)) begin
            prev = vsync_o;
            @(negedge clk);
        end
    endtask

    // one frame, from vsync fall to the next one
    task automatic check_frame();
        int   i;
        int   pix;
        int   hs_falls;
        int   vs_falls;
        int   vs_low;
        logic prev_hs;
        logic prev_vs;
        pix = 0;
        hs_falls = 0;
        vs_falls = 0;
        vs_low = 0;
        wait_vsync_fall();
        prev_hs = hsync_o;
        prev_vs = 1'b1;
        for (i = 0; i < FRAME_CYC; i++) begin
            if (i > 0 && prev_vs && !vsync_o) vs_falls++;
            if (!vsync_o) vs_low++;
            if (prev_hs && !hsync_o) hs_falls++;
            if (visible_o) begin
                if (pix < FRAME_PIX) begin
                    check_rgb($sformatf("rgb pixel %0d", pix), pix_out, expected_pixel(pix));
                end
                pix++;
            end
            prev_hs = hsync_o;
            prev_vs = vsync_o;
            @(negedge clk);
        end
        check_count("visible pixels per frame", pix, FRAME_PIX);
        check_count("hsync pulses per frame", hs_falls, V_TOTAL);
        check_count("extra vsync pulses", vs_falls, 0);
        check_count("vsync low cycles", vs_low, V_SYNC_LEN * H_TOTAL);
        check_bit("vsync_o before next frame", prev_vs, 1'b1);
        check_bit("vsync_o at next frame", vsync_o, 1'b0);
    endtask

    task automatic run_line(input logic [7:0] op, input logic [15:0] a,
                            input logic [15:0] b);
        word_t got;
        int    i;
        case (op)
            "W": reg_write(reg_num_t'(a), b);
            "R": begin
                reg_read(reg_num_t'(a), got);
                check_word($sformatf("register %0d read-back", a), got, b);
            end
            "F": check_frame();
            "M": begin
                // old frame checked while the write lands after line 0
                fork
                    check_frame();
                    begin
                        wait_vsync_fall();
                        repeat (MID_FRAME_CYC) @(negedge clk);
                        reg_write(reg_num_t'(a), b);
                    end
                join
            end
            "S": begin
                for (i = 0; i < a; i++) begin
                    reg_write(REG_DATA, word_t'($urandom));
                end
            end
            "Q": begin
                for (i = 0; i < a; i++) begin
                    reg_write(REG_DATA, b + word_t'(i) * 16'h1357);
                end
            end
            "G": begin
                for (i = 0; i < a; i++) begin
                    reg_write(REG_PAL_DATA, word_t'(b + i * 16'h0125) & 16'h0fff);
                end
            end
            default: stop_run($sformatf("unknown operation %c in tests file", op));
        endcase
    endtask

    // cycles the whole file may take
    task automatic count_budget();
        int          fd;
        int          n;
        int          strobes;
        int          frames;
        string       line;
        logic [7:0]  op;
        logic [15:0] a;
        logic [15:0] b;
        strobes = 0;
        frames = 0;
        fd = $fopen(TESTS_FILE, "r");
        if (fd == 0) begin
            stop_run("cannot open the tests file");
        end else begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%c %h %h", op, a, b);
                if (n == 3 && op != "#") begin
                    case (op)
                        "S", "Q", "G": strobes += 2 * a;
                        "F": frames += 1;
                        "M": begin
                            strobes += 2;
                            frames += 1;
                        end
                        default: strobes += 2;
                    endcase
                end
            end
            $fclose(fd);
            budget_cyc = 4 * FRAME_CYC + strobes * STROBE_CYC + frames * 2 * FRAME_CYC;
        end
    endtask

    initial begin
        wait (budget_cyc > 0);
        repeat (budget_cyc) @(posedge clk);
        stop_run("timeout: the tests did not finish in time");
    end

    initial begin
        string       line;
        int          fd;
        int          n;
        logic [7:0]  op;
        logic [15:0] a;
        logic [15:0] b;
        void'($urandom(SEED));
        count_budget();
        @(posedge rst_n);
        @(negedge clk);
        check_rgb("rgb after reset", pix_out, '0);
        check_bit("hsync_o after reset", hsync_o, 1'b1);
        check_bit("vsync_o after reset", vsync_o, 1'b1);
        check_bit("visible_o after reset", visible_o, 1'b0);
        fd = $fopen(TESTS_FILE, "r");
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%c %h %h", op, a, b);
            if (n == 3 && op != "#") begin
                run_line(op, a, b);
            end
        end
        $fclose(fd);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- tb/vdp_tests.txt
# op reg/count data/base : W write, R read and expect, F frame check, M write mid-frame
# S count random words, Q count pattern words, G count palette colours
R 7 0000
W 2 0001
W 0 0020
W 1 1234
W 1 5678
W 2 0003
W 1 9abc
W 1 def0
W 3 0020
R 4 1234
R 4 5678
R 4 9abc
R 3 0023
W 3 0025
R 4 def0
R 0 0028
F 0 0
W 2 0001
W 0 0000
Q 10 0123
W 5 0000
G 10 0000
W 7 0001
F 0 0
W 0 0000
S 10 0
F 0 0
W 0 0002
M 1 4321
R 7 0001
F 0 0

//--- files.f
common/vdp_pkg.sv
common/ram_if.sv
hw/vdp_ram.sv
hw/bus_port.sv
blit/blitter.sv
video/video_gen.sv
hw/vdp_top.sv
tb/vdp_clkgen.sv
tb/vdp_checker.sv
tb/vdp_tb.sv

//--- run.sh
#!/bin/sh
# compile the display processor testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f files.f --top-module vdp_tb -o vdp_sim

out=$(./obj_dir/vdp_sim 2>&1) || true
echo "$out"

# pass only when the testbench printed its pass line
echo "$out" | grep -qx "Test OK"
